//--- src/fft_pkg.sv
/*
  Shared types for the 8-point radix-2 FFT pipeline. Every module imports
  this package for the sample width, the complex sample and frame structs and the twiddle select.
*/
package fft_pkg;

  ////////////////////
  // sizes
  ////////////////////

  // width of one real or imaginary part
  parameter int SAMPLE_W = 16;

  // samples per frame, power of two
  parameter int FFT_POINTS = 8;

  ////////////////////
  // data types
  ////////////////////

  // one complex sample, re in the upper half
  typedef struct packed {
    logic signed [SAMPLE_W-1:0] re;
    logic signed [SAMPLE_W-1:0] im;
  } cplx_t;

  // whole frame, sample 0 sits in the low bits
  typedef cplx_t [FFT_POINTS-1:0] frame_t;

  ////////////////////
  // twiddle select
  ////////////////////

  // the rotation that a butterfly applies to its b input
  // W^k = exp(-j*2*pi*k/8)
  typedef enum logic [1:0] {
    TW_0 = 2'd0,  // 1
    TW_1 = 2'd1,  // 0.707 - j0.707
    TW_2 = 2'd2,  // -j
    TW_3 = 2'd3   // -0.707 - j0.707
  } twiddle_e;

endpackage

//--- src/frame_loader.sv
/*
  Front end of the FFT pipeline. Captures a frame on write and launches it on start.
  The launched frame is in bit-reversed order, ready for the first stage.
*/
`timescale 1ns/100ps

module frame_loader (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            write,         // capture strobe
  input  logic            start,         // launch level
  input  fft_pkg::frame_t frame_in,
  output fft_pkg::frame_t launch_frame,  // bit-reversed order
  output logic            launch_valid
);

  import fft_pkg::*;

  localparam int IDX_W = $clog2(FFT_POINTS);

  frame_t capture_frame;

  // reverse the low IDX_W bits of a sample index
  function automatic int bit_rev(input int idx);
    int rev;
    rev = 0;
    for (int i = 0; i < IDX_W; i++)
    begin
      rev = (rev << 1) | ((idx >> i) & 1);
    end
    return rev;
  endfunction

  ////////////////////
  // capture register
  ////////////////////

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      capture_frame <= '0;
    end
    else if (write)
    begin
      capture_frame <= frame_in;
    end
  end

  ////////////////////
  // launch register
  ////////////////////

  // on write and start together this still takes the old capture
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      launch_frame <= '0;
      launch_valid <= 1'b0;
    end
    else
    begin
      launch_valid <= start;
      if (start)
      begin
        // sample k goes to slot rev(k), order 0 4 2 6 1 5 3 7
        for (int k = 0; k < FFT_POINTS; k++)
        begin
          launch_frame[bit_rev(k)] <= capture_frame[k];
        end
      end
    end
  end

endmodule

//--- src/butterfly.sv
/*
  Radix-2 decimation-in-time butterfly. Rotates b by the selected twiddle
  and returns a+b*w and a-b*w. Purely combinational, all math wraps at SAMPLE_W bits.
*/
`timescale 1ns/100ps

module butterfly (
  input  fft_pkg::cplx_t    a,
  input  fft_pkg::cplx_t    b,
  input  fft_pkg::twiddle_e twiddle,
  output fft_pkg::cplx_t    sum,
  output fft_pkg::cplx_t    diff
);

  import fft_pkg::*;

  logic signed [SAMPLE_W-1:0] re_plus_im;   // b.re + b.im, wrapped
  logic signed [SAMPLE_W-1:0] im_minus_re;  // b.im - b.re, wrapped
  logic signed [SAMPLE_W-1:0] scaled_sum;
  logic signed [SAMPLE_W-1:0] scaled_diff;
  cplx_t                      bw;           // b times twiddle

  // approximate x * 0.707 with shifts
  // 1/2 + 1/8 + 1/16 + 1/64 + 1/256 + 1/1024 = 0.708...
  function automatic logic signed [SAMPLE_W-1:0] scale(
    input logic signed [SAMPLE_W-1:0] x
  );
    logic signed [SAMPLE_W-1:0] acc;
    acc = (x >>> 1) + (x >>> 3);
    acc = acc + (x >>> 4) + (x >>> 6);
    acc = acc + (x >>> 8) + (x >>> 10);
    return acc;
  endfunction

  ////////////////////
  // twiddle rotation
  ////////////////////

  // inner terms wrap before scaling
  always_comb
  begin
    re_plus_im  = b.re + b.im;
    im_minus_re = b.im - b.re;
    scaled_sum  = scale(re_plus_im);
    scaled_diff = scale(im_minus_re);
  end

  always_comb
  begin
    bw = b;
    case (twiddle)
      TW_0:
      begin
        bw = b;
      end
      TW_1:
      begin
        // 0.707 * ((re+im) + j(im-re))
        bw.re = scaled_sum;
        bw.im = scaled_diff;
      end
      TW_2:
      begin
        bw.re = b.im;          // swap and negate
        bw.im = 16'sd0 - b.re;
      end
      TW_3:
      begin
        // 0.707 * ((im-re) - j(re+im))
        bw.re = scaled_diff;
        bw.im = 16'sd0 - scaled_sum;
      end
      default:
      begin
        bw = b;
      end
    endcase
  end

  ////////////////////
  // add and subtract
  ////////////////////

  always_comb
  begin
    sum.re  = a.re + bw.re;
    sum.im  = a.im + bw.im;
    diff.re = a.re - bw.re;  // lower output of the pair
    diff.im = a.im - bw.im;
  end

endmodule

//--- src/radix2_stage.sv
/*
  One pipeline stage of the FFT: FFT_POINTS/2 butterflies on the registered
  input frame, then the stage output register and valid flag. STAGE picks the pairing span.
*/
`timescale 1ns/100ps

module radix2_stage #(
  parameter int STAGE = 1  // 1, 2 or 3
) (
  input  logic            clk,
  input  logic            reset_n,
  input  fft_pkg::frame_t stage_in,
  input  logic            valid_in,
  output fft_pkg::frame_t stage_out,
  output logic            valid_out
);

  import fft_pkg::*;

  localparam int SPAN   = 1 << (STAGE - 1);  // distance between paired samples
  localparam int NUM_BF = FFT_POINTS / 2;

  cplx_t bf_sum  [NUM_BF];
  cplx_t bf_diff [NUM_BF];

  // upper position of butterfly g, its partner is top_pos(g) + SPAN
  function automatic int top_pos(input int g);
    return (g / SPAN) * 2 * SPAN + (g % SPAN);
  endfunction

  // twiddle exponent grows with the offset inside the block
  function automatic int tw_index(input int g);
    return (g % SPAN) * (FFT_POINTS / (2 * SPAN));
  endfunction

  ////////////////////
  // butterflies
  ////////////////////

  for (genvar g = 0; g < NUM_BF; g++)
  begin : g_bf
    butterfly i_butterfly (
      .a       (stage_in[top_pos(g)]),
      .b       (stage_in[top_pos(g) + SPAN]),
      .twiddle (twiddle_e'(tw_index(g))),
      .sum     (bf_sum[g]),
      .diff    (bf_diff[g])
    );
  end

  ////////////////////
  // stage register
  ////////////////////

  // loads every cycle, valid just tags the data
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      stage_out <= '0;
      valid_out <= 1'b0;
    end
    else
    begin
      for (int g = 0; g < NUM_BF; g++)
      begin
        stage_out[top_pos(g)]        <= bf_sum[g];
        stage_out[top_pos(g) + SPAN] <= bf_diff[g];  // difference goes low
      end
      valid_out <= valid_in;
    end
  end

endmodule

//--- src/fft_top.sv
/*
  Top level of the 8-point pipelined FFT. Write captures a frame, start launches it,
  and the transform appears on frame_out with ready three edges after the start edge.
*/
`timescale 1ns/100ps

module fft_top (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            write,
  input  logic            start,
  input  fft_pkg::frame_t frame_in,
  output fft_pkg::frame_t frame_out,
  output logic            ready
);

  import fft_pkg::*;

  frame_t launch_frame;  // bit-reversed
  logic   launch_valid;
  frame_t s1_frame;
  logic   s1_valid;
  frame_t s2_frame;
  logic   s2_valid;

  ////////////////////
  // capture and launch
  ////////////////////

  frame_loader i_frame_loader (
    .clk          (clk),
    .reset_n      (reset_n),
    .write        (write),
    .start        (start),
    .frame_in     (frame_in),
    .launch_frame (launch_frame),
    .launch_valid (launch_valid)
  );

  ////////////////////
  // three FFT stages
  ////////////////////

  // span 1, W0 only
  radix2_stage #(.STAGE(1)) i_stage1 (
    .clk       (clk),
    .reset_n   (reset_n),
    .stage_in  (launch_frame),
    .valid_in  (launch_valid),
    .stage_out (s1_frame),
    .valid_out (s1_valid)
  );

  // span 2, W0 and W2
  radix2_stage #(.STAGE(2)) i_stage2 (
    .clk       (clk),
    .reset_n   (reset_n),
    .stage_in  (s1_frame),
    .valid_in  (s1_valid),
    .stage_out (s2_frame),
    .valid_out (s2_valid)
  );

  radix2_stage #(.STAGE(3)) i_stage3 (  // natural order out
    .clk       (clk),
    .reset_n   (reset_n),
    .stage_in  (s2_frame),
    .valid_in  (s2_valid),
    .stage_out (frame_out),
    .valid_out (ready)
  );

endmodule

//--- testbench/fft_model.svh
/*
  Reference 8-point DIT FFT for the testbench, worked straight from the flow graph
  with 16-bit wrap after every add. Included inside the testbench module body.
*/
`ifndef FFT_MODEL_SVH
`define FFT_MODEL_SVH

// two's complement wrap to 16 bits
function automatic int wrap16(input int x);
  logic signed [15:0] t;
  t = x[15:0];
  return int'(t);
endfunction

// 0.707 as 1/2 + 1/8 + 1/16 + 1/64 + 1/256 + 1/1024, each term floored
function automatic int scale707(input int x);
  int terms;
  terms = (x >>> 1) + (x >>> 3) + (x >>> 4);
  terms = terms + (x >>> 6) + (x >>> 8) + (x >>> 10);
  return wrap16(terms);
endfunction

// b times W^k for k = 0..3
function automatic void rotate(input int re, input int im, input int k,
                               output int out_re, output int out_im);
  int s;
  int d;
  s = wrap16(re + im);
  d = wrap16(im - re);
  case (k)
    1:
    begin
      out_re = scale707(s);
      out_im = scale707(d);
    end
    2:
    begin
      out_re = im;               // times -j
      out_im = wrap16(0 - re);
    end
    3:
    begin
      out_re = scale707(d);
      out_im = wrap16(0 - scale707(s));
    end
    default:
    begin
      out_re = re;
      out_im = im;
    end
  endcase
endfunction

// 3-bit index reversal
function automatic int rev3(input int k);
  return ((k & 1) << 2) | (k & 2) | ((k >> 2) & 1);
endfunction

function automatic frame_t fft8(input frame_t x);
  int     xr [FFT_POINTS];
  int     xi [FFT_POINTS];
  int     br;
  int     bi;
  int     q;
  frame_t y;
  for (int k = 0; k < FFT_POINTS; k++)
  begin
    xr[rev3(k)] = int'(x[k].re);
    xi[rev3(k)] = int'(x[k].im);
  end
  // spans 1, 2, 4 with twiddle exponent j * 4 / span
  for (int span = 1; span < FFT_POINTS; span = span * 2)
  begin
    for (int p = 0; p < FFT_POINTS; p++)
    begin
      if ((p % (2 * span)) < span)
      begin
        q = p + span;
        rotate(xr[q], xi[q], (p % span) * (4 / span), br, bi);
        xr[q] = wrap16(xr[p] - br);
        xi[q] = wrap16(xi[p] - bi);
        xr[p] = wrap16(xr[p] + br);
        xi[p] = wrap16(xi[p] + bi);
      end
    end
  end
  for (int k = 0; k < FFT_POINTS; k++)
  begin
    y[k].re = 16'(xr[k]);
    y[k].im = 16'(xi[k]);
  end
  return y;
endfunction

`endif

//--- testbench/tb_fft_top.sv
/*
  Testbench for the pipelined 8-point FFT. Random, back-to-back and directed
  frames go through fft_top and every result is checked against fft_model.svh.
*/
`timescale 1ns/100ps

module tb_fft_top;

  import fft_pkg::*;

  `include "fft_model.svh"

  localparam int LATENCY         = 3;
  localparam int STREAM_LEN      = 200;
  localparam int DIRECTED_FRAMES = 17;
  localparam int TEST_CYCLES     = 5 + 12 + 30 + (STREAM_LEN + 10) + (2 * DIRECTED_FRAMES + 10)
                                   + 25;
  localparam int TIMEOUT_CYCLES  = 2 * TEST_CYCLES + 100;

  logic   clk;
  logic   reset_n;
  logic   write;
  logic   start;
  frame_t frame_in;
  frame_t frame_out;
  logic   ready;

  frame_t expected_q[$];  // one entry per launch, oldest first
  frame_t directed_q[$];
  frame_t model_capture;  // tb copy of the capture register
  frame_t last_expected;  // model result of the newest checked launch
  string  test_name;
  int     error_count;
  int     cycle_count;

  fft_top i_fft_top (
    .clk       (clk),
    .reset_n   (reset_n),
    .write     (write),
    .start     (start),
    .frame_in  (frame_in),
    .frame_out (frame_out),
    .ready     (ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // model and checks
  ////////////////////

  // launch takes the capture as it was before this edge
  always @(posedge clk)
  begin
    if (reset_n)
    begin
      if (start)
        expected_q.push_back(fft8(model_capture));
      if (write)
        model_capture = frame_in;
    end
  end

  always @(negedge clk)
  begin
    if (ready)
    begin
      assert (expected_q.size() != 0)
      else
      begin
        error_count++;
        $display("%s: ready is high but no frame was launched", test_name);
      end
      if (expected_q.size() != 0)
      begin
        last_expected = expected_q.pop_front();
        compare_frame(last_expected);
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("%s: run did not finish within %0d cycles", test_name, TIMEOUT_CYCLES);
      $display("errors: %0d", error_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic compare_frame(input frame_t exp_frame);
    for (int k = 0; k < FFT_POINTS; k++)
    begin
      assert (frame_out[k].re == exp_frame[k].re)
      else
      begin
        error_count++;
        $display("mismatch %s: X[%0d].re expected %0d actual %0d",
                 test_name, k, exp_frame[k].re, frame_out[k].re);
      end
      assert (frame_out[k].im == exp_frame[k].im)
      else
      begin
        error_count++;
        $display("mismatch %s: X[%0d].im expected %0d actual %0d",
                 test_name, k, exp_frame[k].im, frame_out[k].im);
      end
    end
  endtask

  task automatic check_reset_outputs();
    assert (!ready)
    else
    begin
      error_count++;
      $display("%s: ready is high around reset", test_name);
    end
    assert (frame_out == '0)
    else
    begin
      error_count++;
      $display("mismatch %s: frame_out expected 0 actual %h", test_name, frame_out);
    end
  endtask

  // wait for all launched frames to come out
  task automatic drain_results();
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < 2 * LATENCY + 2)
    begin
      @(posedge clk);
      waited++;
    end
    assert (expected_q.size() == 0)
    else
    begin
      error_count++;
      $display("%s: %0d launched frames never came out", test_name, expected_q.size());
      expected_q.delete();
    end
  endtask

  task automatic edges_until_ready(input logic level, output int edges);
    edges = 0;
    while (ready !== level && edges < 4 * LATENCY)
    begin
      @(negedge clk);
      edges++;
    end
  endtask

  ////////////////////
  // frame builders
  ////////////////////

  function automatic frame_t random_frame();
    frame_t f;
    for (int k = 0; k < FFT_POINTS; k++)
    begin
      f[k].re = 16'($urandom);
      f[k].im = 16'($urandom);
    end
    return f;
  endfunction

  function automatic frame_t const_frame(input logic signed [15:0] re,
                                         input logic signed [15:0] im);
    frame_t f;
    for (int k = 0; k < FFT_POINTS; k++)
    begin
      f[k].re = re;
      f[k].im = im;
    end
    return f;
  endfunction

  // sign flips every sample, negation wraps
  function automatic frame_t alt_frame(input logic signed [15:0] v);
    frame_t f;
    for (int k = 0; k < FFT_POINTS; k++)
    begin
      f[k].re = (k % 2 == 0) ? v : 16'sd0 - v;
      f[k].im = (k % 2 == 0) ? 16'sd0 - v : v;
    end
    return f;
  endfunction

  ////////////////////
  // test sequence
  ////////////////////

  initial
  begin
    frame_t frame_a;
    frame_t frame_b;
    frame_t held_frame;
    frame_t f;
    int     edges;
    int     fall_edges;

    void'($urandom(32'hdcda_eca9));
    reset_n       = 1'b0;
    write         = 1'b0;
    start         = 1'b0;
    frame_in      = '0;
    model_capture = '0;
    last_expected = '0;
    error_count   = 0;
    cycle_count   = 0;

    test_name = "reset";
    repeat (4)
    begin
      @(negedge clk);
      check_reset_outputs();
    end
    reset_n = 1'b1;
    @(negedge clk);
    check_reset_outputs();

    test_name = "single_frame";
    write    = 1'b1;
    frame_in = random_frame();
    @(negedge clk);
    write = 1'b0;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;  // start edge just passed
    edges_until_ready(1'b1, edges);
    assert (edges == LATENCY)
    else
    begin
      error_count++;
      $display("mismatch %s: latency expected %0d actual %0d", test_name, LATENCY, edges);
    end
    @(negedge clk);
    assert (!ready)
    else
    begin
      error_count++;
      $display("%s: ready stayed high for more than one cycle", test_name);
    end
    drain_results();

    test_name = "capture_vs_launch";
    frame_a = random_frame();
    frame_b = random_frame();
    @(negedge clk);
    write    = 1'b1;
    frame_in = frame_a;
    @(negedge clk);
    frame_in = frame_b;
    start    = 1'b1;  // launches A, captures B
    @(negedge clk);
    write = 1'b0;
    start = 1'b0;
    drain_results();
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    drain_results();
    for (int i = 0; i < 3; i++)
    begin
      @(negedge clk);
      write    = 1'b1;
      frame_in = random_frame();
    end
    @(negedge clk);
    write = 1'b0;
    repeat (2 * LATENCY)
    begin
      @(negedge clk);
      assert (!ready)
      else
      begin
        error_count++;
        $display("%s: write without start raised ready", test_name);
      end
    end

    test_name = "back_to_back";
    for (int i = 0; i < STREAM_LEN; i++)
    begin
      @(negedge clk);
      write    = 1'b1;
      start    = 1'b1;
      frame_in = random_frame();
    end
    @(negedge clk);
    write = 1'b0;
    start = 1'b0;
    drain_results();

    test_name = "directed";
    for (int i = 0; i < FFT_POINTS; i++)
    begin
      f = '0;
      f[i].re = 16'sh7fff;
      f[i].im = 16'sh8000;
      directed_q.push_back(f);
    end
    directed_q.push_back(const_frame(16'sh7fff, 16'sh7fff));
    directed_q.push_back(const_frame(16'sh7fff, 16'sh8001));
    directed_q.push_back(const_frame(16'sh8001, 16'sh7fff));
    directed_q.push_back(alt_frame(16'sh7fff));
    directed_q.push_back(alt_frame(16'sd1000));
    directed_q.push_back(const_frame(16'sh8000, 16'sh8000));  // most negative
    directed_q.push_back(const_frame(16'sh8000, 16'sh0000));
    directed_q.push_back(alt_frame(16'sh8000));
    directed_q.push_back(const_frame(16'sh0000, 16'sh8000));
    foreach (directed_q[i])
    begin
      @(negedge clk);
      write    = 1'b1;
      start    = 1'b0;
      frame_in = directed_q[i];
      @(negedge clk);
      write = 1'b0;
      start = 1'b1;
    end
    @(negedge clk);
    start = 1'b0;
    drain_results();

    test_name = "idle_hold";
    @(negedge clk);
    write    = 1'b1;
    frame_in = random_frame();
    repeat (3)
    begin
      @(negedge clk);
      start    = 1'b1;
      frame_in = random_frame();
    end
    @(negedge clk);
    write = 1'b0;
    start = 1'b0;
    // first edge that sees start low is one edge on
    edges_until_ready(1'b1, edges);
    edges_until_ready(1'b0, fall_edges);
    assert (edges + fall_edges == LATENCY + 1)
    else
    begin
      error_count++;
      $display("mismatch %s: edges to ready low expected %0d actual %0d",
               test_name, LATENCY + 1, edges + fall_edges);
    end
    held_frame = last_expected;  // transform of the last launched frame
    repeat (10)
    begin
      assert (frame_out == held_frame)
      else
      begin
        error_count++;
        $display("mismatch %s: frame_out expected %h actual %h",
                 test_name, held_frame, frame_out);
      end
      assert (!ready)
      else
      begin
        error_count++;
        $display("%s: ready went high while the pipeline was idle", test_name);
      end
      @(negedge clk);
    end
    drain_results();

    $display("errors: %0d", error_count);
    if (error_count == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+testbench
src/fft_pkg.sv
src/frame_loader.sv
src/butterfly.sv
src/radix2_stage.sv
src/fft_top.sv
testbench/tb_fft_top.sv

//--- Bender.yml
package:
  name: fft8_pipeline

sources:
  - src/fft_pkg.sv
  - src/frame_loader.sv
  - src/butterfly.sv
  - src/radix2_stage.sv
  - src/fft_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_fft_top.sv
